//--- tank_pkg.sv
`default_nettype none

package tank_pkg;

	// enemy tank count, also sets the enable and alive mask widths
	localparam int NUM_ENEMIES = 4;

	// hit event buffer
	localparam int HIT_FIFO_DEPTH = 4;
	localparam int FIFO_PTR_W = $clog2(HIT_FIFO_DEPTH);

	typedef enum logic [1:0]
	{
		MODE_IDLE = 2'd0,
		MODE_PLAY = 2'd1,
		MODE_OVER = 2'd2
	} game_mode_t;

	// enemy n is encoded as n, the player as zero
	typedef enum logic [2:0]
	{
		TGT_PLAYER = 3'd0,
		TGT_ENEMY1 = 3'd1,
		TGT_ENEMY2 = 3'd2,
		TGT_ENEMY3 = 3'd3,
		TGT_ENEMY4 = 3'd4
	} target_t;

	typedef logic [2:0] hp_t;
	typedef logic [2:0] dmg_t;

	typedef struct packed
	{
		target_t target;
		dmg_t    damage;
	} hit_event_t;

	typedef struct packed
	{
		logic [NUM_ENEMIES-1:0] bul;
		logic                   mybul;
		logic                   mytank_app;
		logic                   mytank_phy;
		logic [NUM_ENEMIES-1:0] eny_app;
		logic [NUM_ENEMIES-1:0] eny_phy;
	} enable_t;

	typedef struct packed
	{
		hp_t                    player_hp;
		logic [NUM_ENEMIES-1:0] enemy_alive;
	} health_t;

	localparam hp_t PLAYER_HP_INIT = 3'd7;
	localparam hp_t ENEMY_HP_INIT  = 3'd3;

endpackage

`default_nettype wire

//--- apb_pkg.sv
`default_nettype none

package apb_pkg;

	localparam int APB_ADDR_W = 8;
	localparam int APB_DATA_W = 16;

	typedef struct packed
	{
		logic                  psel;
		logic                  penable;
		logic                  pwrite;
		logic [APB_ADDR_W-1:0] paddr;
		logic [APB_DATA_W-1:0] pwdata;
	} apb_req_t;

	typedef struct packed
	{
		logic [APB_DATA_W-1:0] prdata;
		logic                  pready;
		logic                  pslverr;
	} apb_rsp_t;

	// register map
	localparam logic [APB_ADDR_W-1:0] REG_CTRL   = 8'h00;
	localparam logic [APB_ADDR_W-1:0] REG_HIT    = 8'h04;
	localparam logic [APB_ADDR_W-1:0] REG_STATUS = 8'h08;

	// start command bit in REG_CTRL
	localparam int CTRL_START_BIT = 0;

endpackage

`default_nettype wire

//--- event_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module event_fifo
	import tank_pkg::*;
#(
	parameter type payload_t = logic
)
(
	input  wire           clk,
	input  wire           rst_n,
	input  wire           push,
	input  wire payload_t push_data,
	output logic          full,
	input  wire           pop,
	output payload_t      pop_data,
	output logic          empty
);

	payload_t              mem [HIT_FIFO_DEPTH];
	logic [FIFO_PTR_W-1:0] wr_ptr;
	logic [FIFO_PTR_W-1:0] rd_ptr;
	logic [FIFO_PTR_W:0]   count;
	logic                  wr_en;
	logic                  rd_en;

	assign full  = (count == (FIFO_PTR_W + 1)'(HIT_FIFO_DEPTH));
	assign empty = (count == '0);
	assign wr_en = push && !full;
	assign rd_en = pop && !empty;

	// head of the buffer is always visible
	assign pop_data = mem[rd_ptr];

	always_ff @(posedge clk)
	begin
		if (wr_en)
			mem[wr_ptr] <= push_data;
	end

	// pointers wrap on their own since the depth is a power of two
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= rd_ptr + 1'b1;
			case ({wr_en, rd_en})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// producer must honour full
	a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
		full |-> !push);

	// consumer must honour empty
	a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
		empty |-> !pop);

endmodule

`default_nettype wire

//--- hp_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module hp_tracker
	import tank_pkg::*;
(
	input  wire             clk,
	input  wire             rst_n,
	input  wire game_mode_t mode,
	output logic            pop,
	input  wire hit_event_t pop_data,
	input  wire             empty,
	output health_t         health
);

	hp_t  player_hp;
	hp_t  enemy_hp [NUM_ENEMIES];
	logic apply;

	// hp minus damage, floored at zero
	function automatic hp_t sat_sub(input hp_t hp, input dmg_t dmg);
		if (hp > hp_t'(dmg))
			return hp - hp_t'(dmg);
		return '0;
	endfunction

	// events left over from a finished game are flushed while idle
	assign pop   = !empty && (mode == MODE_PLAY || mode == MODE_IDLE);
	assign apply = pop && (mode == MODE_PLAY);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			player_hp <= PLAYER_HP_INIT;
			for (int i = 0; i < NUM_ENEMIES; i++)
				enemy_hp[i] <= ENEMY_HP_INIT;
		end
		else if (mode == MODE_IDLE)
		begin
			// held at full health so PLAY is entered with fresh values
			player_hp <= PLAYER_HP_INIT;
			for (int i = 0; i < NUM_ENEMIES; i++)
				enemy_hp[i] <= ENEMY_HP_INIT;
		end
		else if (apply)
		begin
			if (pop_data.target == TGT_PLAYER)
			begin
				player_hp <= sat_sub(player_hp, pop_data.damage);
			end
			else
			begin
				for (int i = 0; i < NUM_ENEMIES; i++)
				begin
					// a dead enemy stays dead
					if (pop_data.target == target_t'(i + 1) && enemy_hp[i] != '0)
						enemy_hp[i] <= sat_sub(enemy_hp[i], pop_data.damage);
				end
			end
		end
	end

	always_comb
	begin
		health.player_hp = player_hp;
		for (int i = 0; i < NUM_ENEMIES; i++)
			health.enemy_alive[i] = (enemy_hp[i] != '0);
	end

endmodule

`default_nettype wire

//--- game_mode.sv
`timescale 1ns/1ps
`default_nettype none

module game_mode
	import tank_pkg::*;
(
	input  wire          clk,
	input  wire          rst_n,
	input  wire          start,
	input  wire health_t health,
	output game_mode_t   mode,
	output enable_t      enables
);

	game_mode_t mode_nxt;
	enable_t    enables_nxt;

	// idle -> play -> over -> idle
	always_comb
	begin
		mode_nxt = mode;
		case (mode)
			MODE_IDLE:
			begin
				if (start)
					mode_nxt = MODE_PLAY;
			end
			MODE_PLAY:
			begin
				// player destroyed or every enemy gone
				if (health.player_hp == '0 || health.enemy_alive == '0)
					mode_nxt = MODE_OVER;
			end
			MODE_OVER:
			begin
				if (start)
					mode_nxt = MODE_IDLE;
			end
			default:
			begin
				mode_nxt = MODE_IDLE;
			end
		endcase
	end

	// enables are computed from the next mode so they change with it
	always_comb
	begin
		enables_nxt = '0;
		if (mode_nxt == MODE_PLAY)
		begin
			enables_nxt.mybul      = 1'b1;
			enables_nxt.mytank_app = 1'b1;
			enables_nxt.mytank_phy = 1'b1;
			// dead enemies lose their tank and their bullet
			enables_nxt.bul        = health.enemy_alive;
			enables_nxt.eny_app    = health.enemy_alive;
			enables_nxt.eny_phy    = health.enemy_alive;
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			mode    <= MODE_IDLE;
			enables <= '0;
		end
		else
		begin
			mode    <= mode_nxt;
			enables <= enables_nxt;
		end
	end

	// nothing moves outside a running game
	a_enables_off: assert property (@(posedge clk) disable iff (!rst_n)
		mode != MODE_PLAY |-> enables == '0);

	// health is restored before a game starts
	a_full_on_start: assert property (@(posedge clk) disable iff (!rst_n)
		(mode == MODE_IDLE && start) |-> health.player_hp == PLAYER_HP_INIT);

endmodule

`default_nettype wire

//--- apb_game_port.sv
`timescale 1ns/1ps
`default_nettype none

module apb_game_port
	import tank_pkg::*;
	import apb_pkg::*;
(
	input  wire             clk,
	input  wire             rst_n,
	input  wire apb_req_t   req,
	output apb_rsp_t        rsp,
	input  wire game_mode_t mode,
	input  wire health_t    health,
	output logic            start,
	output logic            push,
	output hit_event_t      push_data,
	input  wire             full
);

	logic                  access;
	logic                  in_play;
	logic                  start_req;
	logic [APB_DATA_W-1:0] status_word;

	// access phase of a transfer
	assign access  = req.psel && req.penable;
	assign in_play = (mode == MODE_PLAY);

	// mode in 1:0, player hp in 4:2, enemy alive mask in 8:5
	assign status_word = APB_DATA_W'({health.enemy_alive, health.player_hp, mode});

	assign push_data = hit_event_t'(req.pwdata[$bits(hit_event_t)-1:0]);

	always_comb
	begin
		rsp       = '0;
		push      = 1'b0;
		start_req = 1'b0;
		if (access)
		begin
			case (req.paddr)
				REG_CTRL:
				begin
					rsp.pready = 1'b1;
					start_req  = req.pwrite && req.pwdata[CTRL_START_BIT];
				end
				REG_HIT:
				begin
					if (!req.pwrite)
					begin
						// write only, reads return zero
						rsp.pready = 1'b1;
					end
					else if (!in_play)
					begin
						// no game running, the hit is dropped
						rsp.pready  = 1'b1;
						rsp.pslverr = 1'b1;
					end
					else
					begin
						// hold the host off while the buffer is full
						rsp.pready = !full;
						push       = !full;
					end
				end
				REG_STATUS:
				begin
					rsp.pready = 1'b1;
					if (req.pwrite)
						rsp.pslverr = 1'b1;
					else
						rsp.prdata = status_word;
				end
				default:
				begin
					rsp.pready  = 1'b1;
					rsp.pslverr = 1'b1;
				end
			endcase
		end
	end

	// one-cycle start pulse after the CTRL write completes
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			start <= 1'b0;
		end
		else
		begin
			start <= start_req;
		end
	end

endmodule

`default_nettype wire

//--- tank_game_top.sv
`timescale 1ns/1ps
`default_nettype none

module tank_game_top
	import tank_pkg::*;
	import apb_pkg::*;
(
	input  wire           clk,
	input  wire           rst_n,
	input  wire apb_req_t apb_req,
	output apb_rsp_t      apb_rsp,
	output enable_t       enables
);

	game_mode_t mode;
	health_t    health;
	hit_event_t push_data;
	hit_event_t pop_data;
	logic       start;
	logic       push;
	logic       pop;
	logic       full;
	logic       empty;

	// host side
	apb_game_port u_port (
		.clk       (clk),
		.rst_n     (rst_n),
		.req       (apb_req),
		.rsp       (apb_rsp),
		.mode      (mode),
		.health    (health),
		.start     (start),
		.push      (push),
		.push_data (push_data),
		.full      (full)
	);

	// hit reports waiting for the tracker
	event_fifo #(
		.payload_t (hit_event_t)
	) u_hit_fifo (
		.clk       (clk),
		.rst_n     (rst_n),
		.push      (push),
		.push_data (push_data),
		.full      (full),
		.pop       (pop),
		.pop_data  (pop_data),
		.empty     (empty)
	);

	hp_tracker u_hp (
		.clk      (clk),
		.rst_n    (rst_n),
		.mode     (mode),
		.pop      (pop),
		.pop_data (pop_data),
		.empty    (empty),
		.health   (health)
	);

	game_mode u_mode (
		.clk     (clk),
		.rst_n   (rst_n),
		.start   (start),
		.health  (health),
		.mode    (mode),
		.enables (enables)
	);

endmodule

`default_nettype wire

//--- tb_tank_game.sv
`timescale 1ns/1ps
`default_nettype none

module tb_tank_game
	import tank_pkg::*;
	import apb_pkg::*;
;

	localparam int PREADY_LIMIT = 20;
	localparam int POLL_LIMIT   = 20;
	localparam int ENABLE_LIMIT = 8;

	typedef enum logic [1:0]
	{
		OP_CTRL = 2'd0,
		OP_HIT  = 2'd1,
		OP_POLL = 2'd2
	} op_t;

	// exp_status and exp_en only matter for polls
	typedef struct packed
	{
		op_t                   op;
		logic [APB_DATA_W-1:0] data;
		logic                  exp_err;
		logic [APB_DATA_W-1:0] exp_status;
		enable_t               exp_en;
	} step_t;

	logic     clk;
	logic     rst_n;
	apb_req_t apb_req;
	apb_rsp_t apb_rsp;
	enable_t  enables;

	step_t       steps [$];
	string       step_names [$];
	int          mismatch_count;
	int          timeout_count;

	// reference model of the game used while the table is built
	game_mode_t m_mode;
	hp_t        m_player_hp;
	hp_t        m_enemy_hp [NUM_ENEMIES];

	tank_game_top dut0 (
		.clk     (clk),
		.rst_n   (rst_n),
		.apb_req (apb_req),
		.apb_rsp (apb_rsp),
		.enables (enables)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic hp_t hp_after_hit(input hp_t hp, input dmg_t dmg);
		int left;
		left = int'(hp) - int'(dmg);
		if (left < 0)
			left = 0;
		return hp_t'(left);
	endfunction

	function automatic logic [NUM_ENEMIES-1:0] model_alive();
		logic [NUM_ENEMIES-1:0] alive;
		for (int i = 0; i < NUM_ENEMIES; i++)
			alive[i] = (m_enemy_hp[i] != 3'd0);
		return alive;
	endfunction

	// register layout of REG_STATUS
	function automatic logic [APB_DATA_W-1:0] status_for(input game_mode_t m, input hp_t php,
		input logic [NUM_ENEMIES-1:0] alive);
		logic [APB_DATA_W-1:0] w;
		w      = '0;
		w[1:0] = m;
		w[4:2] = php;
		w[8:5] = alive;
		return w;
	endfunction

	function automatic enable_t enables_for(input game_mode_t m, input logic [NUM_ENEMIES-1:0] alive);
		enable_t e;
		e = '0;
		if (m == MODE_PLAY)
		begin
			e.bul        = alive;
			e.mybul      = 1'b1;
			e.mytank_app = 1'b1;
			e.mytank_phy = 1'b1;
			e.eny_app    = alive;
			e.eny_phy    = alive;
		end
		return e;
	endfunction

	task automatic reload_model();
		m_player_hp = PLAYER_HP_INIT;
		for (int i = 0; i < NUM_ENEMIES; i++)
			m_enemy_hp[i] = ENEMY_HP_INIT;
	endtask

	task automatic add_step(input string name, input op_t op, input logic [APB_DATA_W-1:0] data,
		input logic exp_err);
		step_t s;
		s.op         = op;
		s.data       = data;
		s.exp_err    = exp_err;
		s.exp_status = status_for(m_mode, m_player_hp, model_alive());
		s.exp_en     = enables_for(m_mode, model_alive());
		steps.push_back(s);
		step_names.push_back(name);
	endtask

	task automatic add_ctrl(input string name);
		add_step(name, OP_CTRL, 16'h0001, 1'b0);
		if (m_mode == MODE_IDLE)
			m_mode = MODE_PLAY;
		else if (m_mode == MODE_OVER)
			m_mode = MODE_IDLE;
		reload_model();
	endtask

	task automatic add_hit(input string name, input target_t tgt, input dmg_t dmg);
		hit_event_t ev;
		int         idx;
		ev.target = tgt;
		ev.damage = dmg;
		add_step(name, OP_HIT, {10'd0, ev}, m_mode != MODE_PLAY);
		if (m_mode == MODE_PLAY)
		begin
			if (tgt == TGT_PLAYER)
			begin
				m_player_hp = hp_after_hit(m_player_hp, dmg);
			end
			else
			begin
				idx = int'(tgt) - 1;
				m_enemy_hp[idx] = hp_after_hit(m_enemy_hp[idx], dmg);
			end
		end
	endtask

	task automatic add_poll(input string name);
		// game over once the queued hits have landed
		if (m_mode == MODE_PLAY && (m_player_hp == 3'd0 || model_alive() == '0))
			m_mode = MODE_OVER;
		add_step(name, OP_POLL, '0, 1'b0);
	endtask

	task automatic build_table();
		dmg_t    d;
		dmg_t    first_dmg [NUM_ENEMIES];
		target_t burst_tgt [6];
		m_mode = MODE_IDLE;
		reload_model();
		add_poll("reset_idle");
		add_hit("hit_in_idle", TGT_PLAYER, 3'd2);
		add_poll("idle_after_hit");
		add_ctrl("start_game1");
		add_poll("play_full");
		add_hit("player_hit_a", TGT_PLAYER, dmg_t'(1 + $urandom % 2));
		add_poll("player_hp_a");
		add_hit("player_hit_b", TGT_PLAYER, dmg_t'(1 + $urandom % 2));
		add_poll("player_hp_b");
		d = dmg_t'(1 + $urandom % 2);
		add_hit("enemy2_hit_a", TGT_ENEMY2, d);
		add_poll("enemy2_wounded");
		add_hit("enemy2_hit_b", TGT_ENEMY2, 3'd3 - d);
		add_poll("enemy2_dead");
		add_hit("enemy2_dead_hit", TGT_ENEMY2, 3'd2);
		add_poll("enemy2_stays_dead");
		// more writes than the FIFO holds, no polling in between
		burst_tgt = '{TGT_ENEMY1, TGT_ENEMY3, TGT_ENEMY4, TGT_PLAYER, TGT_ENEMY1, TGT_PLAYER};
		for (int i = 0; i < 6; i++)
		begin
			if (burst_tgt[i] == TGT_PLAYER)
				d = dmg_t'($urandom % 2);
			else
				d = 3'd1;
			add_hit($sformatf("burst1_%0d", i), burst_tgt[i], d);
		end
		add_poll("burst1_health");
		add_hit("player_kill", TGT_PLAYER, 3'd7);
		add_poll("over_player_dead");
		add_hit("hit_in_over", TGT_ENEMY1, 3'd1);
		add_ctrl("back_to_idle");
		add_poll("idle_restored");
		add_ctrl("start_game2");
		add_poll("play_fresh");
		// every enemy gets a wounding hit, then a killing one, some saturating
		for (int e = 0; e < NUM_ENEMIES; e++)
		begin
			first_dmg[e] = dmg_t'(1 + $urandom % 2);
			add_hit($sformatf("burst2_e%0d_a", e + 1), target_t'(e + 1), first_dmg[e]);
		end
		for (int e = 0; e < NUM_ENEMIES; e++)
		begin
			d = dmg_t'(3 - int'(first_dmg[e]) + int'($urandom % 2));
			add_hit($sformatf("burst2_e%0d_b", e + 1), target_t'(e + 1), d);
		end
		add_poll("over_enemies_gone");
	endtask

	task automatic check_rsp(input string name, input logic exp_err, input apb_rsp_t got);
		if (got.pslverr !== exp_err)
		begin
			mismatch_count++;
			$display("Mismatch %s pslverr expected %0b actual %0b", name, exp_err, got.pslverr);
		end
	endtask

	task automatic check_status(input string name, input logic [APB_DATA_W-1:0] exp,
		input logic [APB_DATA_W-1:0] got);
		if (got !== exp)
		begin
			mismatch_count++;
			$display("Mismatch %s status expected %h actual %h", name, exp, got);
		end
	endtask

	task automatic check_enables(input string name, input enable_t exp, input enable_t got);
		if (got !== exp)
		begin
			mismatch_count++;
			$display("Mismatch %s enables expected %h actual %h", name, exp, got);
		end
	endtask

	task automatic apb_transfer(input logic write, input logic [APB_ADDR_W-1:0] addr,
		input logic [APB_DATA_W-1:0] wdata, output apb_rsp_t rsp);
		int   waited;
		logic done;
		@(posedge clk);
		apb_req.psel    <= 1'b1;
		apb_req.penable <= 1'b0;
		apb_req.pwrite  <= write;
		apb_req.paddr   <= addr;
		apb_req.pwdata  <= wdata;
		@(posedge clk);
		apb_req.penable <= 1'b1;
		waited = 0;
		done   = 1'b0;
		rsp    = '0;
		// pready is sampled mid-cycle, the transfer ends on the next edge
		while (!done && waited < PREADY_LIMIT)
		begin
			@(negedge clk);
			if (apb_rsp.pready)
			begin
				rsp  = apb_rsp;
				done = 1'b1;
			end
			else
			begin
				waited++;
			end
		end
		if (!done)
		begin
			timeout_count++;
			$display("timeout: no pready for the access to address %h", addr);
		end
		@(posedge clk);
		apb_req <= '0;
	endtask

	task automatic apb_write(input logic [APB_ADDR_W-1:0] addr, input logic [APB_DATA_W-1:0] data,
		output apb_rsp_t rsp);
		apb_transfer(1'b1, addr, data, rsp);
	endtask

	task automatic apb_read(input logic [APB_ADDR_W-1:0] addr, output apb_rsp_t rsp);
		apb_transfer(1'b0, addr, '0, rsp);
	endtask

	task automatic poll_status(input string name, input logic [APB_DATA_W-1:0] exp_status,
		input enable_t exp_en);
		apb_rsp_t rsp;
		int       polls;
		int       waited;
		polls = 0;
		rsp   = '0;
		do
		begin
			apb_read(REG_STATUS, rsp);
			polls++;
		end
		while (rsp.prdata !== exp_status && polls < POLL_LIMIT);
		if (rsp.prdata !== exp_status)
		begin
			timeout_count++;
			$display("timeout: status for %s never reached the expected value", name);
		end
		check_rsp(name, 1'b0, rsp);
		check_status(name, exp_status, rsp.prdata);
		// enables trail the health by one register stage
		waited = 0;
		@(negedge clk);
		while (enables !== exp_en && waited < ENABLE_LIMIT)
		begin
			@(negedge clk);
			waited++;
		end
		check_enables(name, exp_en, enables);
	endtask

	task automatic run_step(input int i);
		step_t    s;
		apb_rsp_t rsp;
		s = steps[i];
		case (s.op)
			OP_CTRL:
			begin
				apb_write(REG_CTRL, s.data, rsp);
				check_rsp(step_names[i], s.exp_err, rsp);
			end
			OP_HIT:
			begin
				apb_write(REG_HIT, s.data, rsp);
				check_rsp(step_names[i], s.exp_err, rsp);
			end
			default:
			begin
				poll_status(step_names[i], s.exp_status, s.exp_en);
			end
		endcase
	endtask

	initial
	begin
		void'($urandom(84164));
		mismatch_count = 0;
		timeout_count  = 0;
		apb_req        = '0;
		rst_n          = 1'b0;
		build_table();
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		for (int i = 0; i < steps.size(); i++)
			run_step(i);
		repeat (2) @(posedge clk);
		$display("errors: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
		if (mismatch_count == 0 && timeout_count == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
tank_pkg.sv
apb_pkg.sv
event_fifo.sv
hp_tracker.sv
game_mode.sv
apb_game_port.sv
tank_game_top.sv
tb_tank_game.sv

//--- run.sh
#!/bin/sh
# build with Verilator and run the testbench
# exit status is zero only when the pass line shows up in the output

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f list.f --top-module tb_tank_game -o tb_tank_game &&
./obj_dir/tb_tank_game | tee /dev/stderr | grep -qx "sim passed" &&
echo "run.sh: PASS" ||
{
	echo "run.sh: FAIL"
	exit 1
}
